/* Makefile */
TOOL := verilator
TOP := tbMipsCore
FILELIST := compile.f
FLAGS := --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR := obj_dir
SIM := $(OBJDIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu
	import mipsPkg::*;
(
	input aluOpEnum op,
	input word a,
	input word b,
	output word result,
	output logic zero
);

	localparam int shiftWidth = $clog2(dataWidth);

	logic lessSigned;
	logic lessUnsigned;

	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluNor: result = ~(a | b);
			aluSetLess: result = {{(dataWidth-1){1'b0}}, lessSigned};
			aluSetLessUnsigned: result = {{(dataWidth-1){1'b0}}, lessUnsigned};
			aluShiftLeft: result = a << b[shiftWidth-1:0]; // Only low bits of b count
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* compile.f */
mipsPkg.sv
alu.sv
fetchUnit.sv
controlDecoder.sv
registerFile.sv
executeUnit.sv
memoryWriteback.sv
mipsCore.sv
tbMipsCore.sv

/* controlDecoder.sv */
`timescale 1ns/1ps

module controlDecoder
	import mipsPkg::*;
(
	input word instr,
	output aluOpEnum aluOp,
	output aluASel aluASrc,
	output aluBSel aluBSrc,
	output logic immSigned,
	output regDstSel regDst,
	output wbSel wbSrc,
	output logic regWrite,
	output logic memWrite,
	output logic isBranch,
	output logic branchOnEqual,
	output nextPcSrc nextPcSel
);

	opcodeEnum opcode;
	functEnum funct;

	assign opcode = opcodeEnum'(instr[31:26]);
	assign funct = functEnum'(instr[5:0]);

	always_comb begin
		aluOp = aluAdd;
		aluASrc = aSelRs;
		aluBSrc = bSelRt;
		immSigned = 1'b0;
		regDst = dstRt;
		wbSrc = wbAlu;
		regWrite = 1'b0;
		memWrite = 1'b0;
		isBranch = 1'b0;
		branchOnEqual = 1'b0;
		nextPcSel = pcSeq;
		if (instr != '0) begin // Zero word is a NOP
			case (opcode)
				opSpecial: begin
					regDst = dstRd;
					regWrite = 1'b1;
					case (funct)
						fnAdd, fnAddu: aluOp = aluAdd; // No overflow trap
						fnSub, fnSubu: aluOp = aluSub;
						fnAnd: aluOp = aluAnd;
						fnOr: aluOp = aluOr;
						fnXor: aluOp = aluXor;
						fnNor: aluOp = aluNor;
						fnSlt: aluOp = aluSetLess;
						fnSltu: aluOp = aluSetLessUnsigned;
						fnSll: begin
							aluOp = aluShiftLeft;
							aluASrc = aSelRt;
							aluBSrc = bSelShamt;
						end
						fnSllv: begin
							aluOp = aluShiftLeft;
							aluASrc = aSelRt;
							aluBSrc = bSelRsLow;
						end
						fnJr: begin
							regWrite = 1'b0;
							nextPcSel = pcReg;
						end
						default: regWrite = 1'b0;
					endcase
				end
				opAddi, opAddiu: begin
					aluBSrc = bSelImm;
					immSigned = 1'b1;
					regWrite = 1'b1;
				end
				opSlti, opSltiu: begin
					aluOp = (opcode == opSlti) ? aluSetLess : aluSetLessUnsigned;
					aluBSrc = bSelImm;
					immSigned = 1'b1; // SLTIU compares against sign-extended imm
					regWrite = 1'b1;
				end
				opAndi, opOri, opXori: begin
					case (opcode)
						opAndi: aluOp = aluAnd;
						opOri: aluOp = aluOr;
						default: aluOp = aluXor;
					endcase
					aluBSrc = bSelImm;
					regWrite = 1'b1;
				end
				opLui: begin
					aluOp = aluShiftLeft;
					aluBSrc = bSelConst16; // Also routes imm to operand A
					regWrite = 1'b1;
				end
				opLw: begin
					aluBSrc = bSelImm;
					immSigned = 1'b1;
					wbSrc = wbMem;
					regWrite = 1'b1;
				end
				opSw: begin
					aluBSrc = bSelImm;
					immSigned = 1'b1;
					memWrite = 1'b1;
				end
				opBeq, opBne: begin
					aluOp = aluSub;
					immSigned = 1'b1;
					isBranch = 1'b1;
					branchOnEqual = (opcode == opBeq);
				end
				opJ: nextPcSel = pcJump;
				opJal: begin
					nextPcSel = pcJump;
					regDst = dstRa;
					wbSrc = wbLink;
					regWrite = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

/* executeUnit.sv */
`timescale 1ns/1ps

module executeUnit
	import mipsPkg::*;
(
	input word instr,
	input word rsData,
	input word rtData,
	input aluOpEnum aluOp,
	input aluASel aluASrc,
	input aluBSel aluBSrc,
	input logic immSigned,
	input logic isBranch,
	input logic branchOnEqual,
	output word aluResult,
	output logic branchTaken
);

	word extImm;
	word opA;
	word opB;
	logic zero;

	assign extImm = immSigned ? {{(dataWidth-16){instr[15]}}, instr[15:0]}
		: {{(dataWidth-16){1'b0}}, instr[15:0]};

	always_comb begin
		if (aluBSrc == bSelConst16) begin
			opA = extImm; // LUI takes the zero-extended imm
		end else begin
			opA = (aluASrc == aSelRt) ? rtData : rsData;
		end
	end

	always_comb begin
		case (aluBSrc)
			bSelRt: opB = rtData;
			bSelImm: opB = extImm;
			bSelShamt: opB = {{(dataWidth-5){1'b0}}, instr[10:6]};
			bSelRsLow: opB = {{(dataWidth-5){1'b0}}, rsData[4:0]}; // SLLV amount
			bSelConst16: opB = word'(16);
			default: opB = '0;
		endcase
	end

	alu alu0 (
		.op(aluOp),
		.a(opA),
		.b(opB),
		.result(aluResult),
		.zero(zero)
	);

	// BEQ takes on zero, BNE on nonzero
	assign branchTaken = isBranch && (zero == branchOnEqual);

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit
	import mipsPkg::*;
(
	input logic clk,
	input logic rstN,
	input word instr,
	input nextPcSrc nextPcSel,
	input logic branchTaken,
	input word rsData,
	output word pc,
	output word pcPlus4
);

	word branchTarget;
	word jumpTarget;
	word nextPc;

	assign pcPlus4 = pc + word'(4);
	assign branchTarget = pcPlus4 + {{(dataWidth-18){instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget = {pcPlus4[dataWidth-1 -: 4], instr[25:0], 2'b00}; // Same 256MB region

	always_comb begin
		case (nextPcSel)
			pcSeq: nextPc = branchTaken ? branchTarget : pcPlus4;
			pcJump: nextPc = jumpTarget;
			pcReg: nextPc = rsData; // JR
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

/* memoryWriteback.sv */
`timescale 1ns/1ps

module memoryWriteback
	import mipsPkg::*;
#(
	parameter int memWords = 256
) (
	input logic clk,
	input logic rstN,
	input word instr,
	input logic memWrite,
	input regDstSel regDst,
	input wbSel wbSrc,
	input word aluResult,
	input word rtData,
	input word pcPlus4,
	output regAddr regWaddr,
	output word wData
);

	localparam int memAddrWidth = $clog2(memWords);

	word mem [memWords];
	logic [memAddrWidth-1:0] wordAddr;
	word memData;

	assign wordAddr = aluResult[memAddrWidth+1:2]; // Wraps modulo memWords
	assign memData = mem[wordAddr];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= '0;
			end
		end else if (memWrite) begin
			mem[wordAddr] <= rtData;
		end
	end

	always_comb begin
		case (regDst)
			dstRd: regWaddr = instr[15:11];
			dstRa: regWaddr = '1; // $ra
			default: regWaddr = instr[20:16];
		endcase
	end

	always_comb begin
		case (wbSrc)
			wbMem: wData = memData;
			wbLink: wData = pcPlus4;
			default: wData = aluResult;
		endcase
	end

	storeAligned: assert property (@(posedge clk) disable iff (!rstN)
		memWrite |-> aluResult[1:0] == 2'b00);

endmodule

/* mipsCore.sv */
`timescale 1ns/1ps

module mipsCore
	import mipsPkg::*;
#(
	parameter int memWords = 256
) (
	input logic clk,
	input logic rstN,
	input word instr,
	output word pc,
	output logic regWe,
	output regAddr regWaddr,
	output word regWdata
);

	word pcPlus4;
	word rsData;
	word rtData;
	word aluResult;
	aluOpEnum aluOp;
	aluASel aluASrc;
	aluBSel aluBSrc;
	regDstSel regDst;
	wbSel wbSrc;
	nextPcSrc nextPcSel;
	logic immSigned;
	logic memWrite;
	logic isBranch;
	logic branchOnEqual;
	logic branchTaken;

	fetchUnit fetch0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.nextPcSel(nextPcSel),
		.branchTaken(branchTaken),
		.rsData(rsData),
		.pc(pc),
		.pcPlus4(pcPlus4)
	);

	controlDecoder decode0 (
		.instr(instr),
		.aluOp(aluOp),
		.aluASrc(aluASrc),
		.aluBSrc(aluBSrc),
		.immSigned(immSigned),
		.regDst(regDst),
		.wbSrc(wbSrc),
		.regWrite(regWe),
		.memWrite(memWrite),
		.isBranch(isBranch),
		.branchOnEqual(branchOnEqual),
		.nextPcSel(nextPcSel)
	);

	registerFile regs0 (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(instr[25:21]),
		.rtAddr(instr[20:16]),
		.rsData(rsData),
		.rtData(rtData),
		.we(regWe),
		.wAddr(regWaddr),
		.wData(regWdata)
	);

	executeUnit exec0 (
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.aluOp(aluOp),
		.aluASrc(aluASrc),
		.aluBSrc(aluBSrc),
		.immSigned(immSigned),
		.isBranch(isBranch),
		.branchOnEqual(branchOnEqual),
		.aluResult(aluResult),
		.branchTaken(branchTaken)
	);

	memoryWriteback #(
		.memWords(memWords)
	) memWb0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.memWrite(memWrite),
		.regDst(regDst),
		.wbSrc(wbSrc),
		.aluResult(aluResult),
		.rtData(rtData),
		.pcPlus4(pcPlus4),
		.regWaddr(regWaddr),
		.wData(regWdata)
	);

endmodule

/* mipsPkg.sv */
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [dataWidth-1:0] word;
	typedef logic [regAddrWidth-1:0] regAddr;

	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opJ = 6'd2,
		opJal = 6'd3,
		opBeq = 6'd4,
		opBne = 6'd5,
		opAddi = 6'd8,
		opAddiu = 6'd9,
		opSlti = 6'd10,
		opSltiu = 6'd11,
		opAndi = 6'd12,
		opOri = 6'd13,
		opXori = 6'd14,
		opLui = 6'd15,
		opLw = 6'd35,
		opSw = 6'd43
	} opcodeEnum;

	// SPECIAL function field
	typedef enum logic [5:0] {
		fnSll = 6'd0,
		fnSllv = 6'd4,
		fnJr = 6'd8,
		fnAdd = 6'd32,
		fnAddu = 6'd33,
		fnSub = 6'd34,
		fnSubu = 6'd35,
		fnAnd = 6'd36,
		fnOr = 6'd37,
		fnXor = 6'd38,
		fnNor = 6'd39,
		fnSlt = 6'd42,
		fnSltu = 6'd43
	} functEnum;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSetLess,
		aluSetLessUnsigned,
		aluShiftLeft
	} aluOpEnum;

	typedef enum logic {aSelRs, aSelRt} aluASel; // Shifts take rt

	// Five sources need three bits
	typedef enum logic [2:0] {bSelRt, bSelImm, bSelShamt, bSelRsLow, bSelConst16} aluBSel;

	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstSel;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel;

	typedef enum logic [1:0] {pcSeq, pcJump, pcReg} nextPcSrc; // pcSeq covers branches

endpackage

/* registerFile.sv */
`timescale 1ns/1ps

module registerFile
	import mipsPkg::*;
(
	input logic clk,
	input logic rstN,
	input regAddr rsAddr,
	input regAddr rtAddr,
	output word rsData,
	output word rtData,
	input logic we,
	input regAddr wAddr,
	input word wData
);

	localparam int regCount = 2**regAddrWidth;

	word regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wAddr != '0) begin // $zero never written
			regs[wAddr] <= wData;
		end
	end

	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

	wAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
		we |-> !$isunknown(wAddr));

endmodule

/* tbMipsCore.sv */
`timescale 1ns/1ps

module tbMipsCore
	import mipsPkg::*;
();

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int numInstr = 2000;
	localparam int memDepth = 256;
	localparam int cycleLimit = numInstr + resetCycles + 96; // Test length plus margin
	localparam int driveDelay = 2;
	localparam int sampleDelay = clkPeriod - 2 * driveDelay; // 2 ns before the next edge

	localparam logic [5:0] rFuncts [12] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
		fnXor, fnNor, fnSlt, fnSltu, fnSll, fnSllv};
	localparam logic [5:0] iOps [8] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri,
		opXori, opLui};

	string rNames [12] = '{"ADD", "ADDU", "SUB", "SUBU", "AND", "OR", "XOR", "NOR", "SLT",
		"SLTU", "SLL", "SLLV"};
	string iNames [8] = '{"ADDI", "ADDIU", "SLTI", "SLTIU", "ANDI", "ORI", "XORI", "LUI"};

	logic clk;
	logic rstN;
	word instr;
	word pc;
	logic regWe;
	regAddr regWaddr;
	word regWdata;

	word modelRegs [32];
	word modelMem [memDepth];
	word modelPc;

	// Expected results of the current instruction
	logic expWe;
	regAddr expAddr;
	word expData;
	word nextPc;
	logic doStore;
	int storeIdx;
	word storeData;

	integer seed;
	int checkCount;
	int errorCount;
	int cycles;
	logic pendingLoad; // Next instruction reloads the last store
	word lastStore;

	mipsCore #(
		.memWords(memDepth)
	) dut0 (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pc(pc),
		.regWe(regWe),
		.regWaddr(regWaddr),
		.regWdata(regWdata)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < cycleLimit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Verification failed");
		$finish;
	end

	function automatic word iType(input logic [5:0] op, input regAddr rs, input regAddr rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic checkValue(input string testName, input word expected, input word actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("MISMATCH %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	// Picks a base register holding a word-aligned value or falls back to $zero
	task automatic pickAlignedReg(output regAddr idx);
		word r;
		regAddr cand;
		idx = '0;
		for (int t = 0; t < 4; t++) begin
			r = $random(seed);
			cand = r[4:0];
			if (idx == '0 && modelRegs[cand][1:0] == 2'b00) begin
				idx = cand;
			end
		end
	endtask

	task automatic genInstr(output word ins, output string mnem);
		word r;
		regAddr rs;
		regAddr rt;
		regAddr rd;
		regAddr base;
		logic [4:0] sh;
		logic [15:0] imm;
		int kind;
		r = $random(seed);
		rs = r[4:0];
		rt = r[9:5];
		rd = r[14:10];
		sh = r[19:15];
		if (r[20]) begin
			rt = rs; // Forces equal operands now and then
		end
		r = $random(seed);
		imm = r[15:0];
		r = $random(seed);
		kind = int'(r % 32'd28);
		if (pendingLoad) begin
			ins = iType(opLw, lastStore[25:21], rt, lastStore[15:0]);
			mnem = "LW after SW";
			pendingLoad = 1'b0;
		end else if (kind < 12) begin
			ins = {6'd0, rs, rt, rd, (rFuncts[kind] == fnSll) ? sh : 5'd0, rFuncts[kind]};
			mnem = rNames[kind];
		end else if (kind < 20) begin
			if (iOps[kind - 12] == opLui) begin
				rs = '0;
			end
			ins = iType(iOps[kind - 12], rs, rt, imm);
			mnem = iNames[kind - 12];
		end else begin
			case (kind)
				20, 21: begin
					pickAlignedReg(base);
					ins = iType((kind == 20) ? opLw : opSw, base, rt, {imm[15:2], 2'b00});
					mnem = (kind == 20) ? "LW" : "SW";
					pendingLoad = (kind == 21);
					lastStore = ins;
				end
				22: begin
					ins = iType(opBeq, rs, rt, imm);
					mnem = "BEQ";
				end
				23: begin
					ins = iType(opBne, rs, rt, imm);
					mnem = "BNE";
				end
				24, 25: begin
					r = $random(seed);
					ins = {(kind == 24) ? opJ : opJal, r[25:0]};
					mnem = (kind == 24) ? "J" : "JAL";
				end
				26: begin
					pickAlignedReg(base);
					ins = {6'd0, base, 15'd0, fnJr};
					mnem = "JR";
				end
				default: begin
					ins = '0;
					mnem = "NOP";
				end
			endcase
		end
	endtask

	task automatic modelStep(input word ins);
		word a;
		word b;
		word simm;
		word zimm;
		word pc4;
		word addr;
		logic [5:0] op;
		logic [5:0] fn;
		op = ins[31:26];
		fn = ins[5:0];
		a = modelRegs[ins[25:21]];
		b = modelRegs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'h0000, ins[15:0]};
		pc4 = modelPc + 32'd4;
		addr = a + simm;
		expWe = 1'b0;
		expAddr = ins[20:16];
		expData = '0;
		nextPc = pc4;
		doStore = 1'b0;
		storeIdx = int'((addr >> 2) % memDepth);
		storeData = b;
		if (ins != '0) begin
			expWe = 1'b1;
			case (op)
				opSpecial: begin
					expAddr = ins[15:11];
					case (fn)
						fnAdd, fnAddu: expData = a + b;
						fnSub, fnSubu: expData = a - b;
						fnAnd: expData = a & b;
						fnOr: expData = a | b;
						fnXor: expData = a ^ b;
						fnNor: expData = ~(a | b);
						fnSlt: expData = {31'd0, $signed(a) < $signed(b)};
						fnSltu: expData = {31'd0, a < b};
						fnSll: expData = b << ins[10:6];
						fnSllv: expData = b << a[4:0];
						fnJr: begin
							expWe = 1'b0;
							nextPc = a;
						end
						default: expWe = 1'b0;
					endcase
				end
				opAddi, opAddiu: expData = a + simm;
				opSlti: expData = {31'd0, $signed(a) < $signed(simm)};
				opSltiu: expData = {31'd0, a < simm};
				opAndi: expData = a & zimm;
				opOri: expData = a | zimm;
				opXori: expData = a ^ zimm;
				opLui: expData = {ins[15:0], 16'h0000};
				opLw: expData = modelMem[storeIdx];
				opSw: begin
					expWe = 1'b0;
					doStore = 1'b1;
				end
				opBeq, opBne: begin
					expWe = 1'b0;
					if ((a == b) == (op == opBeq)) begin
						nextPc = pc4 + (simm << 2);
					end
				end
				opJ, opJal: begin
					expWe = (op == opJal);
					expAddr = 5'd31;
					expData = pc4; // Return address
					nextPc = {pc4[31:28], ins[25:0], 2'b00};
				end
				default: expWe = 1'b0;
			endcase
		end
	endtask

	initial begin
		word ins;
		string mnem;
		seed = 32'ha676dc6e;
		rstN = 1'b0;
		instr = '0;
		checkCount = 0;
		errorCount = 0;
		pendingLoad = 1'b0;
		lastStore = '0;
		modelPc = '0;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < memDepth; i++) begin
			modelMem[i] = '0;
		end
		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		checkValue("reset pc", '0, pc);
		checkValue("reset regWe", '0, word'(regWe));
		rstN = 1'b1;
		for (int n = 0; n < numInstr; n++) begin
			genInstr(ins, mnem);
			instr = ins;
			modelStep(ins);
			#(sampleDelay);
			checkValue($sformatf("#%0d %s pc", n, mnem), modelPc, pc);
			checkValue($sformatf("#%0d %s regWe", n, mnem), word'(expWe), word'(regWe));
			if (expWe) begin
				checkValue($sformatf("#%0d %s regWaddr", n, mnem), word'(expAddr),
					word'(regWaddr));
				checkValue($sformatf("#%0d %s regWdata", n, mnem), expData, regWdata);
			end
			if (expWe && expAddr != '0) begin
				modelRegs[expAddr] = expData;
			end
			if (doStore) begin
				modelMem[storeIdx] = storeData;
			end
			modelPc = nextPc;
			@(posedge clk);
			#(driveDelay);
		end
		$display("Checks run: %0d, mismatches: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
